// File: rv_defines.svh
// ------------------------------------------------
// RV32I core parameters
// Data width, register count and reset PC shared
// by the core, data path and register file
// ------------------------------------------------

`ifndef RV_DEFINES_SVH
`define RV_DEFINES_SVH

// Data and address width in bits
`define RV_XLEN 32

// Architectural integer registers x0..x31
`define RV_REG_COUNT 32

// First fetch address after reset
`define RV_RESET_PC 32'h0000_0000

`endif

// File: rv_pkg.sv
// ------------------------------------------------
// RV32I core types
// Opcode, ALU function and mux select encodings
// ------------------------------------------------

package rv_pkg;

  // Major opcodes of the supported RV32I subset
  typedef enum logic [6:0] {
    OPC_LUI    = 7'b0110111,
    OPC_AUIPC  = 7'b0010111,
    OPC_JAL    = 7'b1101111,
    OPC_JALR   = 7'b1100111,
    OPC_BRANCH = 7'b1100011,
    OPC_LOAD   = 7'b0000011,
    OPC_STORE  = 7'b0100011,
    OPC_OP_IMM = 7'b0010011,
    OPC_OP     = 7'b0110011
  } opcode_t;

  // ALU functions, the last four only for branch compares
  typedef enum logic [4:0] {
    ALU_ADD  = 5'd0,
    ALU_SUB  = 5'd1,
    ALU_SLL  = 5'd2,
    ALU_SLT  = 5'd3,
    ALU_SLTU = 5'd4,
    ALU_XOR  = 5'd5,
    ALU_SRL  = 5'd6,
    ALU_SRA  = 5'd7,
    ALU_OR   = 5'd8,
    ALU_AND  = 5'd9,
    ALU_SEQ  = 5'd10,
    ALU_SNE  = 5'd11,
    ALU_SGE  = 5'd12,
    ALU_SGEU = 5'd13
  } alu_function_t;

  // Register write-back source
  typedef enum logic [2:0] {
    WB_ALU       = 3'd0,
    WB_MEM       = 3'd1,
    WB_PC_PLUS_4 = 3'd2,
    WB_IMM       = 3'd3
  } writeback_sel_t;

  // Next PC source
  typedef enum logic [1:0] {
    NPC_PLUS_4      = 2'd0,
    NPC_PLUS_IMM    = 2'd1,
    NPC_ALU_ALIGNED = 2'd2
  } next_pc_sel_t;

endpackage

// File: rv_alu.sv
// ------------------------------------------------
// RV32I ALU
// Arithmetic, logic, shift and compare functions
// with a zero flag for the branch decision
// ------------------------------------------------

`timescale 1ns/1ps

`include "rv_defines.svh"

module rv_alu import rv_pkg::*; (
  input  alu_function_t       alu_function,
  input  logic [`RV_XLEN-1:0] operand_a,
  input  logic [`RV_XLEN-1:0] operand_b,
  output logic [`RV_XLEN-1:0] result,
  output logic                result_equal_zero
);

  logic [4:0] shamt;
  logic       less_signed;
  logic       less_unsigned;

  // Shift amount from the low five bits only
  assign shamt         = operand_b[4:0];
  assign less_signed   = $signed(operand_a) < $signed(operand_b);
  assign less_unsigned = operand_a < operand_b;

  always_comb begin
    case (alu_function)
      ALU_ADD:  result = operand_a + operand_b;
      ALU_SUB:  result = operand_a - operand_b;
      ALU_SLL:  result = operand_a << shamt;
      ALU_SLT:  result = {{(`RV_XLEN-1){1'b0}}, less_signed};
      ALU_SLTU: result = {{(`RV_XLEN-1){1'b0}}, less_unsigned};
      ALU_XOR:  result = operand_a ^ operand_b;
      ALU_SRL:  result = operand_a >> shamt;
      ALU_SRA:  result = $unsigned($signed(operand_a) >>> shamt);
      ALU_OR:   result = operand_a | operand_b;
      ALU_AND:  result = operand_a & operand_b;
      // Branch compares give 1 when the branch is taken
      ALU_SEQ:  result = {{(`RV_XLEN-1){1'b0}}, operand_a == operand_b};
      ALU_SNE:  result = {{(`RV_XLEN-1){1'b0}}, operand_a != operand_b};
      ALU_SGE:  result = {{(`RV_XLEN-1){1'b0}}, ~less_signed};
      ALU_SGEU: result = {{(`RV_XLEN-1){1'b0}}, ~less_unsigned};
      default:  result = '0;
    endcase
  end

  assign result_equal_zero = (result == '0);

endmodule

// File: rv_immediate_gen.sv
// ------------------------------------------------
// RV32I immediate generator
// Picks the I, S, B, U or J format by opcode and
// sign-extends it to the data width
// ------------------------------------------------

`timescale 1ns/1ps

`include "rv_defines.svh"

module rv_immediate_gen import rv_pkg::*; (
  input  logic [31:0]         inst,
  output logic [`RV_XLEN-1:0] immediate
);

  opcode_t opcode;

  assign opcode = opcode_t'(inst[6:0]);

  always_comb begin
    case (opcode)
      // I format
      OPC_JALR, OPC_LOAD, OPC_OP_IMM:
        immediate = {{(`RV_XLEN-12){inst[31]}}, inst[31:20]};
      // S format
      OPC_STORE:
        immediate = {{(`RV_XLEN-12){inst[31]}}, inst[31:25], inst[11:7]};
      // B format, offset in halfwords
      OPC_BRANCH:
        immediate = {{(`RV_XLEN-13){inst[31]}}, inst[31], inst[7],
                     inst[30:25], inst[11:8], 1'b0};
      // U format
      OPC_LUI, OPC_AUIPC:
        immediate = {inst[31:12], 12'b0};
      // J format
      OPC_JAL:
        immediate = {{(`RV_XLEN-21){inst[31]}}, inst[31], inst[19:12],
                     inst[20], inst[30:21], 1'b0};
      default:
        immediate = '0;
    endcase
  end

endmodule

// File: rv_regfile.sv
// ------------------------------------------------
// Integer register file
// Two combinational read ports and one clocked
// write port, x0 hardwired to zero
// ------------------------------------------------

`timescale 1ns/1ps

`include "rv_defines.svh"

module rv_regfile (
  input  logic                             clock,
  input  logic [$clog2(`RV_REG_COUNT)-1:0] rs1_address,
  input  logic [$clog2(`RV_REG_COUNT)-1:0] rs2_address,
  input  logic                             write_enable,
  input  logic [$clog2(`RV_REG_COUNT)-1:0] rd_address,
  input  logic [`RV_XLEN-1:0]              rd_data,
  output logic [`RV_XLEN-1:0]              rs1_data,
  output logic [`RV_XLEN-1:0]              rs2_data
);

  logic [`RV_XLEN-1:0] regs [`RV_REG_COUNT];

  // Writes to x0 are dropped
  always_ff @(posedge clock) begin
    if (write_enable && (rd_address != '0)) begin
      regs[rd_address] <= rd_data;
    end
  end

  // x0 reads as zero regardless of array contents
  assign rs1_data = (rs1_address == '0) ? '0 : regs[rs1_address];
  assign rs2_data = (rs2_address == '0) ? '0 : regs[rs2_address];

endmodule

// File: rv_datapath.sv
// ------------------------------------------------
// Single-cycle RV32I data path
// PC register, field decode, operand, write-back
// and next-PC muxes around ALU and register file
// ------------------------------------------------

`timescale 1ns/1ps

`include "rv_defines.svh"

module rv_datapath import rv_pkg::*; (
  input  logic                clock,
  input  logic                rst,
  input  logic [31:0]         inst,
  input  logic [`RV_XLEN-1:0] data_mem_read_data,
  input  alu_function_t       alu_function,
  input  logic                alu_operand_a_select,
  input  logic                alu_operand_b_select,
  input  writeback_sel_t      reg_writeback_select,
  input  next_pc_sel_t        next_pc_select,
  input  logic                pc_write_enable,
  input  logic                regfile_write_enable,
  output logic [`RV_XLEN-1:0] pc,
  output logic [`RV_XLEN-1:0] data_mem_address,
  output logic [`RV_XLEN-1:0] data_mem_write_data,
  output logic                alu_result_equal_zero,
  output logic [6:0]          inst_opcode,
  output logic [2:0]          inst_funct3,
  output logic [6:0]          inst_funct7
);

  logic [$clog2(`RV_REG_COUNT)-1:0] rd_address;
  logic [$clog2(`RV_REG_COUNT)-1:0] rs1_address;
  logic [$clog2(`RV_REG_COUNT)-1:0] rs2_address;

  logic [`RV_XLEN-1:0] rs1_data;
  logic [`RV_XLEN-1:0] rs2_data;
  logic [`RV_XLEN-1:0] immediate;
  logic [`RV_XLEN-1:0] operand_a;
  logic [`RV_XLEN-1:0] operand_b;
  logic [`RV_XLEN-1:0] alu_result;
  logic [`RV_XLEN-1:0] pc_plus_4;
  logic [`RV_XLEN-1:0] pc_plus_imm;
  logic [`RV_XLEN-1:0] writeback_data;
  logic [`RV_XLEN-1:0] next_pc;

  // ------------------------------------------------
  // Instruction fields
  // ------------------------------------------------
  assign inst_opcode = inst[6:0];
  assign rd_address  = inst[11:7];
  assign inst_funct3 = inst[14:12];
  assign rs1_address = inst[19:15];
  assign rs2_address = inst[24:20];
  assign inst_funct7 = inst[31:25];

  // ------------------------------------------------
  // Execute
  // ------------------------------------------------
  // Select 1 picks PC for a and immediate for b
  assign operand_a = alu_operand_a_select ? pc : rs1_data;
  assign operand_b = alu_operand_b_select ? immediate : rs2_data;

  rv_immediate_gen igen (
    .inst      (inst),
    .immediate (immediate)
  );

  rv_regfile regs (
    .clock        (clock),
    .rs1_address  (rs1_address),
    .rs2_address  (rs2_address),
    .write_enable (regfile_write_enable),
    .rd_address   (rd_address),
    .rd_data      (writeback_data),
    .rs1_data     (rs1_data),
    .rs2_data     (rs2_data)
  );

  rv_alu alu_core (
    .alu_function      (alu_function),
    .operand_a         (operand_a),
    .operand_b         (operand_b),
    .result            (alu_result),
    .result_equal_zero (alu_result_equal_zero)
  );

  // Loads and stores address through the ALU sum
  assign data_mem_address    = alu_result;
  assign data_mem_write_data = rs2_data;

  always_comb begin
    case (reg_writeback_select)
      WB_MEM:       writeback_data = data_mem_read_data;
      WB_PC_PLUS_4: writeback_data = pc_plus_4;
      WB_IMM:       writeback_data = immediate;
      default:      writeback_data = alu_result;
    endcase
  end

  // ------------------------------------------------
  // Program counter
  // ------------------------------------------------
  assign pc_plus_4   = pc + `RV_XLEN'd4;
  assign pc_plus_imm = pc + immediate;

  always_comb begin
    case (next_pc_select)
      NPC_PLUS_IMM:    next_pc = pc_plus_imm;
      // JALR target with bit 0 cleared
      NPC_ALU_ALIGNED: next_pc = {alu_result[`RV_XLEN-1:1], 1'b0};
      default:         next_pc = pc_plus_4;
    endcase
  end

  always_ff @(posedge clock) begin
    if (rst) begin
      pc <= `RV_RESET_PC;
    end else if (pc_write_enable) begin
      pc <= next_pc;
    end
  end

  // Branch and jump targets keep fetch on word boundaries
  pc_word_aligned: assert property (@(posedge clock) disable iff (rst) pc[1:0] == 2'b00)
    else $error("PC not word aligned: %h", pc);

endmodule

// File: rv_control.sv
// ------------------------------------------------
// RV32I control unit
// Decodes opcode and function fields into mux
// selects and enables, resolves branches
// ------------------------------------------------

`timescale 1ns/1ps

module rv_control import rv_pkg::*; (
  input  logic           rst,
  input  logic [6:0]     inst_opcode,
  input  logic [2:0]     inst_funct3,
  input  logic [6:0]     inst_funct7,
  input  logic           alu_result_equal_zero,
  output alu_function_t  alu_function,
  output logic           alu_operand_a_select,
  output logic           alu_operand_b_select,
  output writeback_sel_t reg_writeback_select,
  output next_pc_sel_t   next_pc_select,
  output logic           regfile_write_enable,
  output logic           pc_write_enable,
  output logic           data_mem_write
);

  opcode_t opcode;

  assign opcode = opcode_t'(inst_opcode);

  // OP and OP-IMM function from funct3, alt picks SUB or SRA
  function automatic alu_function_t op_function(input logic [2:0] funct3, input logic alt);
    case (funct3)
      3'b000:  return alt ? ALU_SUB : ALU_ADD;
      3'b001:  return ALU_SLL;
      3'b010:  return ALU_SLT;
      3'b011:  return ALU_SLTU;
      3'b100:  return ALU_XOR;
      3'b101:  return alt ? ALU_SRA : ALU_SRL;
      3'b110:  return ALU_OR;
      default: return ALU_AND;
    endcase
  endfunction

  // Branch funct3 to a compare that yields 1 when taken
  function automatic alu_function_t branch_function(input logic [2:0] funct3);
    case (funct3)
      3'b001:  return ALU_SNE;
      3'b100:  return ALU_SLT;
      3'b101:  return ALU_SGE;
      3'b110:  return ALU_SLTU;
      3'b111:  return ALU_SGEU;
      default: return ALU_SEQ;
    endcase
  endfunction

  always_comb begin
    // Defaults retire as a no-op with PC+4
    alu_function         = ALU_ADD;
    alu_operand_a_select = 1'b0;
    alu_operand_b_select = 1'b0;
    reg_writeback_select = WB_ALU;
    next_pc_select       = NPC_PLUS_4;
    regfile_write_enable = 1'b0;
    pc_write_enable      = 1'b1;
    data_mem_write       = 1'b0;

    case (opcode)
      OPC_LUI: begin
        reg_writeback_select = WB_IMM;
        regfile_write_enable = 1'b1;
      end
      OPC_AUIPC: begin
        alu_operand_a_select = 1'b1;
        alu_operand_b_select = 1'b1;
        regfile_write_enable = 1'b1;
      end
      OPC_JAL: begin
        reg_writeback_select = WB_PC_PLUS_4;
        next_pc_select       = NPC_PLUS_IMM;
        regfile_write_enable = 1'b1;
      end
      OPC_JALR: begin
        alu_operand_b_select = 1'b1;
        reg_writeback_select = WB_PC_PLUS_4;
        next_pc_select       = NPC_ALU_ALIGNED;
        regfile_write_enable = 1'b1;
      end
      OPC_BRANCH: begin
        alu_function   = branch_function(inst_funct3);
        next_pc_select = alu_result_equal_zero ? NPC_PLUS_4 : NPC_PLUS_IMM;
      end
      OPC_LOAD: begin
        alu_operand_b_select = 1'b1;
        reg_writeback_select = WB_MEM;
        regfile_write_enable = 1'b1;
      end
      OPC_STORE: begin
        alu_operand_b_select = 1'b1;
        data_mem_write       = 1'b1;
      end
      OPC_OP_IMM: begin
        // No SUBI so funct7 only matters for SRAI
        alu_function = op_function(inst_funct3, (inst_funct3 == 3'b101) && inst_funct7[5]);
        alu_operand_b_select = 1'b1;
        regfile_write_enable = 1'b1;
      end
      OPC_OP: begin
        alu_function         = op_function(inst_funct3, inst_funct7[5]);
        regfile_write_enable = 1'b1;
      end
      default: begin
      end
    endcase

    // Hold all state updates while in reset
    if (rst) begin
      pc_write_enable      = 1'b0;
      regfile_write_enable = 1'b0;
      data_mem_write       = 1'b0;
    end
  end

endmodule

// File: rv_core.sv
// ------------------------------------------------
// Single-cycle RV32I core
// Control unit and data path joined to external
// instruction and data memory ports
// ------------------------------------------------

`timescale 1ns/1ps

`include "rv_defines.svh"

module rv_core import rv_pkg::*; (
  input  logic                clock,
  input  logic                rst,
  input  logic [31:0]         inst,
  input  logic [`RV_XLEN-1:0] data_mem_read_data,
  output logic [`RV_XLEN-1:0] inst_addr,
  output logic [`RV_XLEN-1:0] data_mem_address,
  output logic [`RV_XLEN-1:0] data_mem_write_data,
  output logic                data_mem_write
);

  // Decode fields and flag toward control
  logic [6:0]     inst_opcode;
  logic [2:0]     inst_funct3;
  logic [6:0]     inst_funct7;
  logic           alu_result_equal_zero;

  // Selects and enables toward the data path
  alu_function_t  alu_function;
  logic           alu_operand_a_select;
  logic           alu_operand_b_select;
  writeback_sel_t reg_writeback_select;
  next_pc_sel_t   next_pc_select;
  logic           regfile_write_enable;
  logic           pc_write_enable;

  rv_control control (
    .rst                   (rst),
    .inst_opcode           (inst_opcode),
    .inst_funct3           (inst_funct3),
    .inst_funct7           (inst_funct7),
    .alu_result_equal_zero (alu_result_equal_zero),
    .alu_function          (alu_function),
    .alu_operand_a_select  (alu_operand_a_select),
    .alu_operand_b_select  (alu_operand_b_select),
    .reg_writeback_select  (reg_writeback_select),
    .next_pc_select        (next_pc_select),
    .regfile_write_enable  (regfile_write_enable),
    .pc_write_enable       (pc_write_enable),
    .data_mem_write        (data_mem_write)
  );

  rv_datapath datapath (
    .clock                 (clock),
    .rst                   (rst),
    .inst                  (inst),
    .data_mem_read_data    (data_mem_read_data),
    .alu_function          (alu_function),
    .alu_operand_a_select  (alu_operand_a_select),
    .alu_operand_b_select  (alu_operand_b_select),
    .reg_writeback_select  (reg_writeback_select),
    .next_pc_select        (next_pc_select),
    .pc_write_enable       (pc_write_enable),
    .regfile_write_enable  (regfile_write_enable),
    .pc                    (inst_addr),
    .data_mem_address      (data_mem_address),
    .data_mem_write_data   (data_mem_write_data),
    .alu_result_equal_zero (alu_result_equal_zero),
    .inst_opcode           (inst_opcode),
    .inst_funct3           (inst_funct3),
    .inst_funct7           (inst_funct7)
  );

endmodule

// File: tb_rv_iss.svh
// ------------------------------------------------
// Reference RV32I model for the core testbench
// Stimulus LFSR and a one-instruction ISS step
// ------------------------------------------------

`ifndef TB_RV_ISS_SVH
`define TB_RV_ISS_SVH

logic [15:0]         lfsr_state = 16'd22607;
logic [`RV_XLEN-1:0] ref_regs [`RV_REG_COUNT];
logic [`RV_XLEN-1:0] ref_mem [256];
logic [`RV_XLEN-1:0] ref_pc;

// 16-bit Fibonacci LFSR, taps 16 14 13 11
function automatic logic take_bit();
  logic feedback;
  feedback   = lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10];
  take_bit   = lfsr_state[15];
  lfsr_state = {lfsr_state[14:0], feedback};
endfunction

function automatic logic [31:0] random_bits(input int count);
  logic [31:0] value;
  value = '0;
  for (int i = 0; i < count; i++) begin
    value = {value[30:0], take_bit()};
  end
  return value;
endfunction

// Integer ops per RV32I, alt selects SUB and SRA
function automatic logic [`RV_XLEN-1:0] alu_reference(input logic [2:0] funct3,
    input logic alt, input logic [`RV_XLEN-1:0] a, input logic [`RV_XLEN-1:0] b);
  logic [`RV_XLEN-1:0] shifted;
  case (funct3)
    3'b000:  return alt ? (a - b) : (a + b);
    3'b001:  return a << b[4:0];
    3'b010:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
    3'b011:  return (a < b) ? 32'd1 : 32'd0;
    3'b100:  return a ^ b;
    3'b101: begin
      if (alt) begin
        shifted = $signed(a) >>> b[4:0];
      end else begin
        shifted = a >> b[4:0];
      end
      return shifted;
    end
    3'b110:  return a | b;
    default: return a & b;
  endcase
endfunction

// One instruction, returns the next PC and any store
function automatic logic [`RV_XLEN-1:0] execute_instruction(
  input  logic [31:0]         instr,
  output logic                store_en,
  output logic [`RV_XLEN-1:0] store_address,
  output logic [`RV_XLEN-1:0] store_data
);
  logic [`RV_XLEN-1:0] a;
  logic [`RV_XLEN-1:0] b;
  logic [`RV_XLEN-1:0] imm_i;
  logic [`RV_XLEN-1:0] imm_s;
  logic [`RV_XLEN-1:0] imm_b;
  logic [`RV_XLEN-1:0] imm_u;
  logic [`RV_XLEN-1:0] imm_j;
  logic [`RV_XLEN-1:0] result;
  logic [`RV_XLEN-1:0] next_pc;
  logic                write_rd;
  logic                taken;
  a             = ref_regs[instr[19:15]];
  b             = ref_regs[instr[24:20]];
  imm_i         = {{20{instr[31]}}, instr[31:20]};
  imm_s         = {{20{instr[31]}}, instr[31:25], instr[11:7]};
  imm_b         = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
  imm_u         = {instr[31:12], 12'b0};
  imm_j         = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};
  next_pc       = ref_pc + 32'd4;
  result        = '0;
  write_rd      = 1'b0;
  store_en      = 1'b0;
  store_address = '0;
  store_data    = '0;
  case (opcode_t'(instr[6:0]))
    OPC_LUI: begin
      result   = imm_u;
      write_rd = 1'b1;
    end
    OPC_AUIPC: begin
      result   = ref_pc + imm_u;
      write_rd = 1'b1;
    end
    OPC_JAL: begin
      result   = ref_pc + 32'd4;
      next_pc  = ref_pc + imm_j;
      write_rd = 1'b1;
    end
    OPC_JALR: begin
      result   = ref_pc + 32'd4;
      next_pc  = (a + imm_i) & ~32'd1;
      write_rd = 1'b1;
    end
    OPC_BRANCH: begin
      case (instr[14:12])
        3'b000:  taken = (a == b);
        3'b001:  taken = (a != b);
        3'b100:  taken = ($signed(a) < $signed(b));
        3'b101:  taken = ($signed(a) >= $signed(b));
        3'b110:  taken = (a < b);
        default: taken = (a >= b);
      endcase
      if (taken) begin
        next_pc = ref_pc + imm_b;
      end
    end
    OPC_LOAD: begin
      result   = ref_mem[(a + imm_i) >> 2];
      write_rd = 1'b1;
    end
    OPC_STORE: begin
      store_en      = 1'b1;
      store_address = a + imm_s;
      store_data    = b;
      ref_mem[store_address[9:2]] = b;
    end
    OPC_OP_IMM: begin
      result   = alu_reference(instr[14:12], (instr[14:12] == 3'b101) && instr[30], a, imm_i);
      write_rd = 1'b1;
    end
    OPC_OP: begin
      result   = alu_reference(instr[14:12], instr[30], a, b);
      write_rd = 1'b1;
    end
    default: begin
    end
  endcase
  // x0 stays zero
  if (write_rd && (instr[11:7] != 5'd0)) begin
    ref_regs[instr[11:7]] = result;
  end
  return next_pc;
endfunction

`endif

// File: tb_rv_core.sv
// ------------------------------------------------
// Testbench for the single-cycle RV32I core
// Memory models, random program and a reference
// model compared against PC and store traffic
// ------------------------------------------------

`timescale 1ns/1ps

`include "rv_defines.svh"

module tb_rv_core import rv_pkg::*; ();

  localparam int RANDOM_COUNT = 150;
  localparam int LAST_INDEX   = 63 + RANDOM_COUNT;
  localparam int MAX_CYCLES   = 1000;

  logic                clock;
  logic                rst;
  logic [31:0]         inst;
  logic [`RV_XLEN-1:0] data_mem_read_data;
  logic [`RV_XLEN-1:0] inst_addr;
  logic [`RV_XLEN-1:0] data_mem_address;
  logic [`RV_XLEN-1:0] data_mem_write_data;
  logic                data_mem_write;

  logic [31:0]         imem [256];
  logic [`RV_XLEN-1:0] dmem [256];
  logic [`RV_XLEN-1:0] end_pc;
  logic                reached_end;

  `include "tb_rv_iss.svh"

  rv_core UUT (
    .clock               (clock),
    .rst                 (rst),
    .inst                (inst),
    .data_mem_read_data  (data_mem_read_data),
    .inst_addr           (inst_addr),
    .data_mem_address    (data_mem_address),
    .data_mem_write_data (data_mem_write_data),
    .data_mem_write      (data_mem_write)
  );

  // ------------------------------------------------
  // Memory models
  // ------------------------------------------------
  assign inst               = imem[inst_addr[9:2]];
  assign data_mem_read_data = dmem[data_mem_address[9:2]];

  always @(posedge clock) begin
    if (data_mem_write) begin
      dmem[data_mem_address[9:2]] <= data_mem_write_data;
    end
  end

  function automatic logic [31:0] fill_word(input int index);
    return {8'hc3, 8'(index), ~8'(index), 8'(index) ^ 8'h5a};
  endfunction

  // Instruction formats
  function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [4:0] rs2,
      input logic [4:0] rs1, input logic [2:0] f3, input logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, OPC_OP};
  endfunction

  function automatic logic [31:0] i_type(input logic [11:0] imm, input logic [4:0] rs1,
      input logic [2:0] f3, input logic [4:0] rd, input opcode_t op);
    return {imm, rs1, f3, rd, op};
  endfunction

  function automatic logic [31:0] s_type(input logic [11:0] imm, input logic [4:0] rs2,
      input logic [4:0] rs1);
    return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], OPC_STORE};
  endfunction

  function automatic logic [31:0] b_type(input logic [12:0] off, input logic [4:0] rs2,
      input logic [4:0] rs1, input logic [2:0] f3);
    return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], OPC_BRANCH};
  endfunction

  function automatic logic [31:0] u_type(input logic [19:0] imm, input logic [4:0] rd,
      input opcode_t op);
    return {imm, rd, op};
  endfunction

  function automatic logic [31:0] j_type(input logic [20:0] off, input logic [4:0] rd);
    return {off[20], off[10:1], off[11], off[19:12], rd, OPC_JAL};
  endfunction

  // ------------------------------------------------
  // Program generation
  // ------------------------------------------------
  task automatic build_program();
    int          n;
    int          k;
    logic [3:0]  pick;
    logic [4:0]  rd;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic [2:0]  f3;
    logic [11:0] imm;
    for (int i = 0; i < 256; i++) begin
      imem[i] = '0;
    end
    // Store at the reset PC so its strobe has to be masked during reset
    imem[0] = s_type(12'd0, 5'd0, 5'd0);
    n = 1;
    // Known start values in x1..x31
    for (int r = 1; r < 32; r++) begin
      imem[n]     = u_type(20'(random_bits(20)), 5'(r), OPC_LUI);
      imem[n + 1] = i_type(12'(random_bits(12)), 5'(r), 3'b000, 5'(r), OPC_OP_IMM);
      n = n + 2;
    end
    while (n < LAST_INDEX) begin
      rd   = 5'(random_bits(5));
      rs1  = 5'(random_bits(5));
      rs2  = 5'(random_bits(5));
      f3   = 3'(random_bits(3));
      imm  = 12'(random_bits(12));
      pick = 4'(random_bits(4));
      // Forward distance in words, clipped at the self-loop
      k = int'(random_bits(2)) + 1;
      if (n + k > LAST_INDEX) begin
        k = LAST_INDEX - n;
      end
      case (pick)
        4'd0, 4'd1, 4'd2, 4'd3, 4'd4: begin
          imem[n] = r_type((f3 == 3'b000 || f3 == 3'b101) ? {1'b0, imm[0], 5'b0} : 7'b0,
                           rs2, rs1, f3, rd);
        end
        4'd5, 4'd6, 4'd7: begin
          if (f3 == 3'b001) begin
            imm = {7'b0, imm[4:0]};
          end else if (f3 == 3'b101) begin
            imm = {1'b0, imm[10], 5'b0, imm[4:0]};
          end
          imem[n] = i_type(imm, rs1, f3, rd, OPC_OP_IMM);
        end
        4'd8:              imem[n] = u_type({imm, imm[7:0]}, rd,
                                            opcode_t'(imm[11] ? OPC_AUIPC : OPC_LUI));
        4'd9, 4'd10, 4'd11: imem[n] = s_type({2'b00, imm[7:0], 2'b00}, rs2, 5'd0);
        4'd12: imem[n] = i_type({2'b00, imm[7:0], 2'b00}, 5'd0, 3'b010, rd, OPC_LOAD);
        4'd13: begin
          if (f3 == 3'b010 || f3 == 3'b011) begin
            f3[2] = 1'b1;
          end
          imem[n] = b_type(13'(k * 4), rs2, rs1, f3);
        end
        4'd14:   imem[n] = j_type(21'(k * 4), rd);
        // Absolute target from x0, odd half the time
        default: imem[n] = i_type(12'((n + k) * 4 + imm[0]), 5'd0, 3'b000, rd, OPC_JALR);
      endcase
      n = n + 1;
    end
    imem[LAST_INDEX] = j_type(21'd0, 5'd0);
    end_pc = `RV_XLEN'(LAST_INDEX * 4);
  endtask

  // ------------------------------------------------
  // Checks
  // ------------------------------------------------
  task automatic report_mismatch(input string name, input logic [`RV_XLEN-1:0] actual,
      input logic [`RV_XLEN-1:0] expected);
    $display("MISMATCH %s: got %h expected %h (ref pc %h)", name, actual, expected, ref_pc);
    $display("TEST FAILED");
    $fatal(1, "Core output differs from the reference model");
  endtask

  task automatic compare_pc(input logic [`RV_XLEN-1:0] actual,
      input logic [`RV_XLEN-1:0] expected);
    if (actual !== expected) begin
      report_mismatch("inst_addr", actual, expected);
    end
  endtask

  task automatic compare_store(input logic actual_write,
      input logic [`RV_XLEN-1:0] actual_address, input logic [`RV_XLEN-1:0] actual_data,
      input logic expected_write, input logic [`RV_XLEN-1:0] expected_address,
      input logic [`RV_XLEN-1:0] expected_data);
    if (actual_write !== expected_write) begin
      report_mismatch("data_mem_write", {31'b0, actual_write}, {31'b0, expected_write});
    end else if (expected_write && (actual_address !== expected_address)) begin
      report_mismatch("data_mem_address", actual_address, expected_address);
    end else if (expected_write && (actual_data !== expected_data)) begin
      report_mismatch("data_mem_write_data", actual_data, expected_data);
    end
  endtask

  initial begin
    clock = 1'b0;
    forever begin
      #20 clock = ~clock;
    end
  end

  // Compare process, sampled at the rising edge before state updates
  initial begin : compare_process
    logic                exp_write;
    logic [`RV_XLEN-1:0] exp_address;
    logic [`RV_XLEN-1:0] exp_data;
    logic [`RV_XLEN-1:0] next_pc;
    int                  cycle;
    cycle = 0;
    @(posedge clock);
    while (rst && cycle < 10) begin
      compare_store(data_mem_write, data_mem_address, data_mem_write_data, 1'b0, '0, '0);
      @(posedge clock);
      cycle++;
    end
    if (rst) begin
      $display("TEST FAILED");
      $fatal(1, "Reset was never released");
    end
    cycle = 0;
    while (!reached_end && cycle < MAX_CYCLES) begin
      compare_pc(inst_addr, ref_pc);
      next_pc = execute_instruction(imem[ref_pc[9:2]], exp_write, exp_address, exp_data);
      compare_store(data_mem_write, data_mem_address, data_mem_write_data,
                    exp_write, exp_address, exp_data);
      if (ref_pc == end_pc) begin
        reached_end = 1'b1;
      end
      ref_pc = next_pc;
      @(posedge clock);
      cycle++;
    end
  end

  initial begin : run_control
    int cycles;
    rst         = 1'b1;
    reached_end = 1'b0;
    ref_pc      = `RV_RESET_PC;
    build_program();
    for (int i = 0; i < 256; i++) begin
      dmem[i]    = fill_word(i);
      ref_mem[i] = fill_word(i);
    end
    for (int i = 0; i < `RV_REG_COUNT; i++) begin
      ref_regs[i] = '0;
    end
    repeat (3) @(negedge clock);
    rst    = 1'b0;
    cycles = 0;
    // End flag is set at the rising edge, so look at the falling one
    while (!reached_end && cycles < MAX_CYCLES) begin
      @(negedge clock);
      cycles++;
    end
    if (reached_end) begin
      $display("TEST OK");
      $finish;
    end else begin
      $display("TEST FAILED");
      $fatal(1, "Program never reached its final self-loop within the cycle limit");
    end
  end

endmodule

// File: files.f
+incdir+.
rv_pkg.sv
rv_alu.sv
rv_immediate_gen.sv
rv_regfile.sv
rv_datapath.sv
rv_control.sv
rv_core.sv
tb_rv_core.sv

// File: Bender.yml
package:
  name: rv32i_core

export_include_dirs:
  - .

sources:
  - include_dirs:
      - .
    files:
      - rv_pkg.sv
      - rv_alu.sv
      - rv_immediate_gen.sv
      - rv_regfile.sv
      - rv_datapath.sv
      - rv_control.sv
      - rv_core.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_rv_core.sv
